//--- verilog/mem_cfg.svh
// Memory configuration macros for the AXI4-Lite simulation memory
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// First byte address of the memory window
`define MEM_BASE_ADDR 32'h0002_0000

// Byte address bits of the storage, 16 gives 64 KiB
`define MEM_ADDR_BITS 16

// Number of 32-bit words held by the RAM
`define MEM_WORDS (1 << (`MEM_ADDR_BITS - 2))

// Idle cycles between request accept and RAM access, 0 allowed
`define MEM_WAIT_STATES 3

`endif

//--- verilog/mem_pkg.sv
// Shared types for the memory, word views, bus response codes and word index
`include "mem_cfg.svh"

package mem_pkg;

    // One memory word, seen whole by the bus or lane by lane by the RAM
    typedef union packed {
        logic [31:0]     word;   // Bus view
        logic [3:0][7:0] bytes;  // Lane view, index 0 is bits 7:0
    } mem_word_t;

    // AXI response codes used by this slave
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

    // Word index into storage
    typedef logic [`MEM_ADDR_BITS-3:0] mem_index_t;

endpackage

//--- verilog/mem_addr_decode.sv
// Address decoder, maps a bus address into the memory window and flags misses
`include "mem_cfg.svh"

module mem_addr_decode (
    input  logic [31:0]         addr,
    output mem_pkg::mem_index_t index,
    output logic                in_range
);

    logic [31:0] offset;       // Byte offset from window start
    logic        above_base;   // Address not below the base
    logic        inside_size;  // Offset fits the storage

    assign offset      = addr - `MEM_BASE_ADDR;    // Wraps when below base
    assign above_base  = (addr >= `MEM_BASE_ADDR);
    assign inside_size = (offset < (32'd1 << `MEM_ADDR_BITS));

    // Upper half of the address map never belongs to this memory
    assign in_range = !addr[31] && above_base && inside_size;

    // Word aligned, low two bits ignored
    assign index = offset[`MEM_ADDR_BITS-1:2];

endmodule

//--- verilog/mem_byte_ram.sv
// Byte-lane RAM with strobed writes and a one-cycle registered word read
`include "mem_cfg.svh"

module mem_byte_ram (
    input  logic                clock,
    input  logic                write_en,
    input  logic                read_en,
    input  mem_pkg::mem_index_t index,
    input  logic [3:0]          strb,
    input  mem_pkg::mem_word_t  wdata,
    output mem_pkg::mem_word_t  rdata
);

    import mem_pkg::*;

    // Storage array, starts cleared
    mem_word_t storage [`MEM_WORDS] = '{default: '0};

    // Write side, one lane per strobe bit
    always_ff @(posedge clock) begin
        if (write_en) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (strb[lane]) begin
                    storage[index].bytes[lane] <= wdata.bytes[lane];  // Only strobed lanes
                end
            end
        end
    end

    // Read side, word appears the cycle after read_en
    always_ff @(posedge clock) begin
        if (read_en) begin
            rdata <= storage[index];  // Holds until next read
        end
    end

endmodule

//--- verilog/mem_wait_timer.sv
// Wait-state timer, counts the configured idle cycles after each request
`include "mem_cfg.svh"

module mem_wait_timer (
    input  logic clock,
    input  logic rst_n,
    input  logic start,
    output logic done
);

    localparam int WAIT_CYCLES = `MEM_WAIT_STATES;
    // At least one bit so zero wait states still builds
    localparam int CNT_BITS = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

    logic [CNT_BITS-1:0] count;  // Cycles still to wait
    logic                busy;   // Countdown in progress

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            count <= '0;
            busy  <= 1'b0;
        end else if (start) begin
            count <= CNT_BITS'(WAIT_CYCLES);  // Reload on every request
            busy  <= 1'b1;
        end else if (busy) begin
            if (count == '0) begin
                busy <= 1'b0;          // Done already shown
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // One-cycle pulse when the count has run out
    assign done = busy && (count == '0);

endmodule

//--- verilog/mem_access_fsm.sv
// AXI4-Lite slave FSM, sequences handshakes, wait timer, RAM access and responses
module mem_access_fsm (
    input  logic               clock,
    input  logic               rst_n,
    // Write address and data
    input  logic               awvalid,
    output logic               awready,
    input  logic [31:0]        awaddr,
    input  logic               wvalid,
    output logic               wready,
    input  logic [31:0]        wdata,
    input  logic [3:0]         wstrb,
    // Write response
    output logic               bvalid,
    input  logic               bready,
    output mem_pkg::axi_resp_t bresp,
    // Read address and data
    input  logic               arvalid,
    output logic               arready,
    input  logic [31:0]        araddr,
    output logic               rvalid,
    input  logic               rready,
    output logic [31:0]        rdata,
    output mem_pkg::axi_resp_t rresp,
    // Decoder
    output logic [31:0]        req_addr,
    input  logic               in_range,
    // Timer
    output logic               timer_start,
    input  logic               timer_done,
    // RAM
    output logic               ram_write_en,
    output logic               ram_read_en,
    output logic [3:0]         ram_strb,
    output mem_pkg::mem_word_t ram_wdata,
    input  mem_pkg::mem_word_t ram_rdata
);

    import mem_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WR_WAIT,
        ST_RD_WAIT,
        ST_RD_CAPTURE,
        ST_WR_RESP,
        ST_RD_RESP
    } state_t;

    state_t     state;
    logic       aw_fire;   // AW and W taken together
    logic       ar_fire;   // AR taken
    logic [3:0] req_strb;  // Latched write strobes

    // Accept only when idle, write wins over read
    assign aw_fire = (state == ST_IDLE) && awvalid && wvalid;
    assign ar_fire = (state == ST_IDLE) && arvalid && !(awvalid && wvalid);

    assign awready     = aw_fire;
    assign wready      = aw_fire;
    assign arready     = ar_fire;
    assign timer_start = aw_fire || ar_fire;  // Countdown from the accept edge

    assign ram_strb = in_range ? req_strb : 4'b0000;  // Misses store nothing
    assign rdata    = in_range ? ram_rdata.word : 32'h0;  // Zero data on a miss

    // Control path
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            bvalid       <= 1'b0;
            rvalid       <= 1'b0;
            ram_write_en <= 1'b0;
            ram_read_en  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (aw_fire) begin
                        state <= ST_WR_WAIT;
                    end else if (ar_fire) begin
                        state <= ST_RD_WAIT;
                    end
                end
                ST_WR_WAIT: begin
                    if (ram_write_en) begin
                        ram_write_en <= 1'b0;  // RAM took the write this edge
                        bvalid       <= 1'b1;
                        state        <= ST_WR_RESP;
                    end else if (timer_done) begin
                        ram_write_en <= 1'b1;
                    end
                end
                ST_RD_WAIT: begin
                    if (timer_done) begin
                        ram_read_en <= 1'b1;
                        state       <= ST_RD_CAPTURE;
                    end
                end
                ST_RD_CAPTURE: begin
                    ram_read_en <= 1'b0;  // Word lands in RAM output reg
                    rvalid      <= 1'b1;
                    state       <= ST_RD_RESP;
                end
                ST_WR_RESP: begin
                    if (bready) begin
                        bvalid <= 1'b0;
                        state  <= ST_IDLE;
                    end
                end
                ST_RD_RESP: begin
                    if (rready) begin
                        rvalid <= 1'b0;
                        state  <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Request and response payload
    always_ff @(posedge clock) begin
        if (aw_fire) begin
            req_addr       <= awaddr;
            ram_wdata.word <= wdata;
            req_strb       <= wstrb;
        end else if (ar_fire) begin
            req_addr <= araddr;
        end
        if (state == ST_WR_WAIT && ram_write_en) begin
            bresp <= in_range ? OKAY : SLVERR;
        end
        if (state == ST_RD_CAPTURE) begin
            rresp <= in_range ? OKAY : SLVERR;
        end
    end

endmodule

//--- verilog/mem_axil_top.sv
// AXI4-Lite simulation memory top, joins FSM, decoder, wait timer and RAM
module mem_axil_top (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               awvalid,
    output logic               awready,
    input  logic [31:0]        awaddr,
    input  logic               wvalid,
    output logic               wready,
    input  logic [31:0]        wdata,
    input  logic [3:0]         wstrb,
    output logic               bvalid,
    input  logic               bready,
    output mem_pkg::axi_resp_t bresp,
    input  logic               arvalid,
    output logic               arready,
    input  logic [31:0]        araddr,
    output logic               rvalid,
    input  logic               rready,
    output logic [31:0]        rdata,
    output mem_pkg::axi_resp_t rresp
);

    import mem_pkg::*;

    logic [31:0] req_addr;      // Latched request address
    logic        in_range;      // Request hits the window
    mem_index_t  index;         // Word index for the RAM
    logic        timer_start;
    logic        timer_done;
    logic        ram_write_en;
    logic        ram_read_en;
    logic [3:0]  ram_strb;      // Already gated by in_range
    mem_word_t   ram_wdata;
    mem_word_t   ram_rdata;

    mem_access_fsm u_fsm (
        .clock        (clock),
        .rst_n        (rst_n),
        .awvalid      (awvalid),
        .awready      (awready),
        .awaddr       (awaddr),
        .wvalid       (wvalid),
        .wready       (wready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .bvalid       (bvalid),
        .bready       (bready),
        .bresp        (bresp),
        .arvalid      (arvalid),
        .arready      (arready),
        .araddr       (araddr),
        .rvalid       (rvalid),
        .rready       (rready),
        .rdata        (rdata),
        .rresp        (rresp),
        .req_addr     (req_addr),
        .in_range     (in_range),
        .timer_start  (timer_start),
        .timer_done   (timer_done),
        .ram_write_en (ram_write_en),
        .ram_read_en  (ram_read_en),
        .ram_strb     (ram_strb),
        .ram_wdata    (ram_wdata),
        .ram_rdata    (ram_rdata)
    );

    mem_addr_decode u_decode (
        .addr     (req_addr),
        .index    (index),
        .in_range (in_range)
    );

    mem_wait_timer u_timer (
        .clock (clock),
        .rst_n (rst_n),
        .start (timer_start),
        .done  (timer_done)
    );

    mem_byte_ram u_ram (
        .clock    (clock),
        .write_en (ram_write_en),
        .read_en  (ram_read_en),
        .index    (index),
        .strb     (ram_strb),
        .wdata    (ram_wdata),
        .rdata    (ram_rdata)
    );

endmodule

//--- tb/tb_clock_gen.sv
// Testbench clock and reset source, 10 unit clock period and a 4 cycle reset
module tb_clock_gen (
    output logic clock,
    output logic rst_n
);

    // Free running clock, first rising edge at 5
    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Reset held low over the first 4 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clock);
        #1;
        rst_n = 1'b1;  // Released off the edge like other inputs
    end

endmodule

//--- tb/tb_mem_axil.sv
// Directed testbench for the AXI4-Lite simulation memory with a byte-lane model
`include "mem_cfg.svh"

module tb_mem_axil;

    import mem_pkg::*;

    localparam int TIMEOUT = 50;                    // Cycles allowed per wait loop
    localparam int LATENCY = `MEM_WAIT_STATES + 2;  // Handshake edge to valid

    logic        clock;
    logic        rst_n;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    logic [31:0] awaddr, wdata, araddr, rdata;
    logic [3:0]  wstrb;
    axi_resp_t   bresp, rresp;
    int          seed;

    // Expected memory contents, one entry per byte of the window
    logic [7:0] model [(1 << `MEM_ADDR_BITS)] = '{default: 8'h00};

    tb_clock_gen u_clk (
        .clock (clock),
        .rst_n (rst_n)
    );

    mem_axil_top uut (
        .clock   (clock),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic channel_timeout(input string channel);
        $display("timeout at time %0t: no answer on the %s channel", $time, channel);
        abort_run();
    endtask

    task automatic expect_true(input logic cond, input string what);
        if (cond !== 1'b1) begin
            $display("error at time %0t: %s", $time, what);
            abort_run();
        end
    endtask

    task automatic check_word(input mem_word_t got, input mem_word_t exp, input string what);
        if (got.word !== exp.word) begin
            $display("mismatch at time %0t: %s, got %h, expected %h",
                     $time, what, got.word, exp.word);
            abort_run();
        end
    endtask

    task automatic check_resp(input axi_resp_t got, input axi_resp_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s, got %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_latency(input int got, input string what);
        if (got != LATENCY) begin
            $display("mismatch at time %0t: %s took %0d cycles, expected %0d",
                     $time, what, got, LATENCY);
            abort_run();
        end
    endtask

    // Window hit: between first and last byte of the window, upper half excluded
    function automatic logic in_window(input logic [31:0] addr);
        logic [31:0] last;
        last = `MEM_BASE_ADDR + (32'd1 << `MEM_ADDR_BITS) - 32'd1;
        return (addr[31] == 1'b0) && (addr >= `MEM_BASE_ADDR) && (addr <= last);
    endfunction

    // Model position of lane 0 of the addressed word
    function automatic int lane0_of(input logic [31:0] addr);
        return int'((addr - `MEM_BASE_ADDR) & 32'hFFFF_FFFC);  // Low two bits dropped
    endfunction

    function automatic mem_word_t model_read(input logic [31:0] addr);
        mem_word_t w;
        int        first;
        w.word = 32'h0;  // Misses read as zero
        if (in_window(addr)) begin
            first = lane0_of(addr);
            for (int lane = 0; lane < 4; lane++) begin
                w.bytes[2'(lane)] = model[first + lane];
            end
        end
        return w;
    endfunction

    function automatic void model_write(input logic [31:0] addr, input mem_word_t data,
                                        input logic [3:0] strb);
        int first;
        if (in_window(addr)) begin
            first = lane0_of(addr);
            for (int lane = 0; lane < 4; lane++) begin
                if (strb[2'(lane)]) model[first + lane] = data.bytes[2'(lane)];
            end
        end
    endfunction

    // Write transaction, bready held low for hold cycles once bvalid shows
    task automatic axi_write(input logic [31:0] addr, input mem_word_t data,
                             input logic [3:0] strb, input int hold,
                             output axi_resp_t resp, output int lat);
        int waited;
        awaddr  = addr;
        wdata   = data.word;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        waited  = 0;
        do begin
            @(negedge clock);
            waited++;
            if (waited > TIMEOUT) channel_timeout("write address");
        end while (!(awready && wready));
        @(posedge clock);  // AW and W transfer here
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        lat     = 0;
        @(negedge clock);
        while (!bvalid) begin
            @(negedge clock);
            lat++;
            if (lat > TIMEOUT) channel_timeout("write response");
        end
        resp = bresp;
        repeat (hold) begin
            @(negedge clock);
            expect_true(bvalid, "bvalid dropped while bready was low");
            check_resp(bresp, resp, "bresp under back-pressure");
            expect_true(!(awready || wready || arready), "ready raised during write response");
        end
        @(posedge clock);
        #1;
        bready = 1'b1;
        @(negedge clock);
        expect_true(bvalid, "bvalid low when bready rose");
        @(posedge clock);  // B transfer
        #1;
        bready = 1'b0;
    endtask

    // Read transaction, rready held low for hold cycles once rvalid shows
    task automatic axi_read(input logic [31:0] addr, input int hold,
                            output mem_word_t data, output axi_resp_t resp, output int lat);
        int waited;
        araddr  = addr;
        arvalid = 1'b1;
        waited  = 0;
        do begin
            @(negedge clock);
            waited++;
            if (waited > TIMEOUT) channel_timeout("read address");
        end while (!arready);
        @(posedge clock);  // AR transfer here
        #1;
        arvalid = 1'b0;
        lat     = 0;
        @(negedge clock);
        while (!rvalid) begin
            @(negedge clock);
            lat++;
            if (lat > TIMEOUT) channel_timeout("read data");
        end
        data.word = rdata;
        resp      = rresp;
        repeat (hold) begin
            @(negedge clock);
            expect_true(rvalid, "rvalid dropped while rready was low");
            check_word(rdata, data, "rdata under back-pressure");
            check_resp(rresp, resp, "rresp under back-pressure");
            expect_true(!(awready || wready || arready), "ready raised during read response");
        end
        @(posedge clock);
        #1;
        rready = 1'b1;
        @(negedge clock);
        expect_true(rvalid, "rvalid low when rready rose");
        @(posedge clock);  // R transfer
        #1;
        rready = 1'b0;
    endtask

    // Full-word write request raised once a read response is waiting
    task automatic raise_write_behind_read(input logic [31:0] addr, input logic [31:0] value);
        int waited;
        waited = 0;
        do begin
            @(posedge clock);
            #1;
            waited++;
            if (waited > TIMEOUT) channel_timeout("read data");
        end while (!rvalid);
        awaddr  = addr;
        wdata   = value;
        wstrb   = 4'hF;
        awvalid = 1'b1;  // Held until the write task takes it over
        wvalid  = 1'b1;
    endtask

    task automatic write_and_check(input logic [31:0] addr, input logic [31:0] value,
                                   input logic [3:0] strb, input int hold);
        mem_word_t data;
        axi_resp_t resp;
        int        lat;
        data.word = value;
        axi_write(addr, data, strb, hold, resp, lat);
        check_resp(resp, in_window(addr) ? OKAY : SLVERR, "bresp");
        check_latency(lat, "write handshake to bvalid");
        model_write(addr, data, strb);
    endtask

    task automatic read_and_check(input logic [31:0] addr, input int hold);
        mem_word_t data;
        axi_resp_t resp;
        int        lat;
        axi_read(addr, hold, data, resp, lat);
        check_resp(resp, in_window(addr) ? OKAY : SLVERR, "rresp");
        check_word(data, model_read(addr), "rdata");
        check_latency(lat, "read handshake to rvalid");
    endtask

    task automatic full_word_rw();
        write_and_check(`MEM_BASE_ADDR,            32'h0123_4567, 4'hF, 0);
        write_and_check(`MEM_BASE_ADDR + 32'h4,    32'h89AB_CDEF, 4'hF, 0);
        write_and_check(`MEM_BASE_ADDR + 32'h100,  32'hA5A5_5A5A, 4'hF, 0);
        write_and_check(`MEM_BASE_ADDR + 32'hFFFC, 32'hFEED_C0DE, 4'hF, 0);  // Last word
        read_and_check(`MEM_BASE_ADDR, 0);
        read_and_check(`MEM_BASE_ADDR + 32'h4, 0);
        read_and_check(`MEM_BASE_ADDR + 32'h100, 0);
        read_and_check(`MEM_BASE_ADDR + 32'hFFFC, 0);
    endtask

    task automatic partial_strobe_rw();
        write_and_check(`MEM_BASE_ADDR + 32'h20, 32'h1122_3344, 4'hF, 0);
        write_and_check(`MEM_BASE_ADDR + 32'h20, 32'hAAAA_AAAA, 4'b0100, 0);  // One byte
        read_and_check(`MEM_BASE_ADDR + 32'h20, 0);
        write_and_check(`MEM_BASE_ADDR + 32'h20, 32'h5555_6666, 4'b0011, 0);  // Low half
        read_and_check(`MEM_BASE_ADDR + 32'h20, 0);
        write_and_check(`MEM_BASE_ADDR + 32'h20, 32'h7700_0000, 4'b1000, 0);
        write_and_check(`MEM_BASE_ADDR + 32'h20, 32'h0000_0000, 4'b0000, 0);  // No lanes
        read_and_check(`MEM_BASE_ADDR + 32'h20, 0);
    endtask

    task automatic out_of_range_access();
        // Below base aliases the top word, bit 31 aliases word 1, past the end word 0
        write_and_check(`MEM_BASE_ADDR - 32'h4,        32'hDEAD_BEEF, 4'hF, 0);
        write_and_check(32'h8002_0004,                 32'hDEAD_BEEF, 4'hF, 0);
        write_and_check(`MEM_BASE_ADDR + 32'h1_0000,   32'hDEAD_BEEF, 4'hF, 0);
        read_and_check(`MEM_BASE_ADDR - 32'h4, 0);
        read_and_check(32'h8002_0004, 0);
        read_and_check(`MEM_BASE_ADDR + 32'h1_0000, 0);
        read_and_check(`MEM_BASE_ADDR, 0);
        read_and_check(`MEM_BASE_ADDR + 32'h4, 0);
        read_and_check(`MEM_BASE_ADDR + 32'hFFFC, 0);
    endtask

    task automatic latency_count();
        write_and_check(`MEM_BASE_ADDR + 32'h30, 32'h0BAD_F00D, 4'hF, 0);
        read_and_check(`MEM_BASE_ADDR + 32'h30, 0);
        write_and_check(32'h0001_0000, 32'h1234_5678, 4'hF, 0);  // Miss, same latency
        read_and_check(32'h0001_0000, 0);
    endtask

    task automatic back_pressure_hold();
        araddr  = `MEM_BASE_ADDR + 32'h40;
        arvalid = 1'b1;  // Read raised with the write, write must win
        write_and_check(`MEM_BASE_ADDR + 32'h40, 32'hCAFE_F00D, 4'hF, 6);
        fork
            read_and_check(`MEM_BASE_ADDR + 32'h40, 6);  // Sees the new word
            raise_write_behind_read(`MEM_BASE_ADDR + 32'h44, 32'h600D_D00D);
        join
        write_and_check(`MEM_BASE_ADDR + 32'h44, 32'h600D_D00D, 4'hF, 0);  // Pending write
        read_and_check(`MEM_BASE_ADDR + 32'h44, 0);
        read_and_check(32'h8000_0000, 4);
    endtask

    task automatic random_traffic();
        logic [31:0] addr;
        logic [31:0] value;
        logic [3:0]  strb;
        for (int n = 0; n < 80; n++) begin
            addr  = `MEM_BASE_ADDR + {24'h0, 6'($random(seed)), 2'b00};  // 64 words
            value = $random(seed);
            strb  = 4'($random(seed));
            if (1'($random(seed))) begin
                write_and_check(addr, value, strb, 0);
            end else begin
                read_and_check(addr, 0);
            end
        end
    endtask

    initial begin
        int waited;
        seed    = 30;
        awvalid = 1'b0;
        awaddr  = 32'h0;
        wvalid  = 1'b0;
        wdata   = 32'h0;
        wstrb   = 4'h0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = 32'h0;
        rready  = 1'b0;
        waited  = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clock);
            waited++;
            if (waited > TIMEOUT) begin
                $display("error: reset was never released");
                abort_run();
            end
        end
        @(posedge clock);
        #1;
        full_word_rw();
        partial_strobe_rw();
        out_of_range_access();
        latency_count();
        back_pressure_hold();
        random_traffic();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- compile.f
+incdir+verilog
verilog/mem_pkg.sv
verilog/mem_addr_decode.sv
verilog/mem_byte_ram.sv
verilog/mem_wait_timer.sv
verilog/mem_access_fsm.sv
verilog/mem_axil_top.sv
tb/tb_clock_gen.sv
tb/tb_mem_axil.sv

//--- run_sim.sh
#!/bin/sh
# Builds the AXI4-Lite memory testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -j 0 --top-module tb_mem_axil \
    -f compile.f --Mdir "$BUILD_DIR" -o tb_mem_axil
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_mem_axil" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG_FILE"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi
